/* verilog/lsu_pkg.sv */
// Load/store unit shared definitions
// Segment register indices, byte-lane masks, FSM state codes
// and the bus data word seen as a word or as two byte lanes

package lsu_pkg;

  // Segment register indices
  localparam logic [1:0] seg_es = 2'd0;
  localparam logic [1:0] seg_cs = 2'd1;
  localparam logic [1:0] seg_ss = 2'd2;
  localparam logic [1:0] seg_ds = 2'd3;

  // Byte lane masks, bit 0 is the even byte
  localparam logic [1:0] bytesel_none = 2'b00;
  localparam logic [1:0] bytesel_lo   = 2'b01;
  localparam logic [1:0] bytesel_hi   = 2'b10;
  localparam logic [1:0] bytesel_word = 2'b11;

  // Bus sequencer states
  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_issue      = 3'd1;  // Raise m_access
  localparam logic [2:0] st_wait_ack   = 3'd2;
  localparam logic [2:0] st_complete   = 3'd3;
  localparam logic [2:0] st_complete_0 = 3'd4;  // Gap before next order

  typedef struct packed {
    logic [7:0] hi;  // Odd address lane
    logic [7:0] lo;  // Even address lane
  } bus_bytes_t;

  typedef union packed {
    logic [15:0] word;
    bus_bytes_t  bytes;
  } bus_word_u;

endpackage

/* verilog/seg_reg_file.sv */
// Segment register file
// Holds ES, CS, SS and DS with one write port and one
// combinational read port for address generation

`timescale 1ns/100ps

module seg_reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic        seg_write,
  input  logic [1:0]  seg_wsel,
  input  logic [15:0] seg_in,
  input  logic [1:0]  seg_rsel,
  output logic [15:0] segment
);
  import lsu_pkg::*;

  logic [15:0] es, cs, ss, ds;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      es <= 16'h0000;
      cs <= 16'h0000;
      ss <= 16'h0000;
      ds <= 16'h0000;
    end else if (seg_write) begin
      case (seg_wsel)
        seg_es:  es <= seg_in;
        seg_cs:  cs <= seg_in;
        seg_ss:  ss <= seg_in;
        default: ds <= seg_in;
      endcase
    end
  end

  // Read follows seg_rsel in the same cycle
  always_comb begin
    case (seg_rsel)
      seg_es:  segment = es;
      seg_cs:  segment = cs;
      seg_ss:  segment = ss;
      default: segment = ds;
    endcase
  end

  a_wsel_known: assert property (@(posedge clk) disable iff (reset)
    seg_write |-> !$isunknown(seg_wsel));

endmodule

/* verilog/load_store.sv */
// Load/store unit
// Keeps MAR and MDR and runs the external bus sequencer.
// Forms segment*16+offset, picks byte lanes and splits an
// odd memory word into two byte cycles. I/O goes out on MAR
// alone and is never split.

`timescale 1ns/100ps

module load_store (
  input  logic              clk,
  input  logic              reset,

  // Microcode side
  input  logic              write_mar,
  input  logic [15:0]       mar_in,
  input  logic              write_mdr,
  input  lsu_pkg::bus_word_u mdr_in,
  input  logic [15:0]       segment,    // From segment register file
  input  logic              mem_read,   // Level order
  input  logic              mem_write,  // Level order
  input  logic              io,
  input  logic              is_8bit,
  output logic [15:0]       mar_out,
  output lsu_pkg::bus_word_u mdr_out,
  output logic              busy,       // Stalls the microcode

  // External bus
  output logic [19:1]       m_addr,     // Word address
  input  lsu_pkg::bus_word_u m_data_in,
  output lsu_pkg::bus_word_u m_data_out,
  output logic [1:0]        m_bytesel,
  output logic              m_wr_en,
  output logic              m_io,
  output logic              m_access,
  input  logic              m_ack
);
  import lsu_pkg::*;

  logic [15:0] mar;
  bus_word_u   mdr;
  logic [2:0]  state;
  logic        complete;
  logic        split;         // Odd memory word, two bus cycles
  logic        second;        // Second half of a split transfer
  logic        wr_q;          // Transfer is a write
  logic [19:0] phys_addr;
  logic [1:0]  first_lanes;
  bus_word_u   wr_data;

  assign busy = (mem_read | mem_write) & ~complete;

  assign phys_addr = {segment, 4'h0} + {4'h0, mar};

  // Lanes for the first (or only) bus cycle
  always_comb begin
    if (is_8bit)
      first_lanes = mar[0] ? bytesel_hi : bytesel_lo;
    else if (mar[0] && !io)
      first_lanes = bytesel_hi;   // Split, odd byte first
    else
      first_lanes = bytesel_word;
  end

  // MDR low byte goes to the addressed lane
  always_comb begin
    wr_data.word = 16'h0000;
    if (second)
      wr_data.bytes.lo = mdr.bytes.hi;
    else if (m_bytesel == bytesel_word)
      wr_data.word = mdr.word;
    else if (m_bytesel == bytesel_hi)
      wr_data.bytes.hi = mdr.bytes.lo;
    else
      wr_data.bytes.lo = mdr.bytes.lo;
  end

  // ========================================
  // Bus sequencer
  // ========================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= st_idle;
      complete   <= 1'b0;
      split      <= 1'b0;
      second     <= 1'b0;
      wr_q       <= 1'b0;
      mdr        <= '0;
      m_addr     <= '0;
      m_data_out <= '0;
      m_bytesel  <= bytesel_none;
      m_wr_en    <= 1'b0;
      m_io       <= 1'b0;
      m_access   <= 1'b0;
    end else begin
      if (write_mdr) mdr <= mdr_in;

      case (state)
        st_idle: begin
          if (mem_read || mem_write) begin
            wr_q      <= mem_write;
            second    <= 1'b0;
            split     <= !io && !is_8bit && mar[0];
            m_io      <= io;
            m_bytesel <= first_lanes;
            // I/O bypasses the segment
            m_addr    <= io ? {4'h0, mar[15:1]} : phys_addr[19:1];
            state     <= st_issue;
          end
        end

        st_issue: begin
          m_access   <= 1'b1;
          m_wr_en    <= wr_q;
          m_data_out <= wr_q ? wr_data : '0;
          state      <= st_wait_ack;
        end

        st_wait_ack: begin
          if (m_ack) begin
            m_access <= 1'b0;
            m_wr_en  <= 1'b0;

            // Read data is valid in the ack cycle
            if (!m_wr_en) begin
              if (split && !second)
                mdr.bytes.lo <= m_data_in.bytes.hi;
              else if (second)
                mdr.bytes.hi <= m_data_in.bytes.lo;
              else if (m_bytesel == bytesel_word)
                mdr <= m_data_in;
              else if (m_bytesel == bytesel_hi)
                mdr.word <= {8'h00, m_data_in.bytes.hi};   // Zero extend
              else
                mdr.word <= {8'h00, m_data_in.bytes.lo};
            end

            if (split && !second) begin
              second    <= 1'b1;
              m_addr    <= m_addr + 19'd1;     // Next word, low lane
              m_bytesel <= bytesel_lo;
              state     <= st_issue;
            end else begin
              complete   <= 1'b1;
              m_addr     <= '0;                // Quiet bus between transfers
              m_data_out <= '0;
              m_bytesel  <= bytesel_none;
              m_io       <= 1'b0;
              state      <= st_complete;
            end
          end
        end

        st_complete: state <= st_complete_0;

        st_complete_0: begin
          complete <= 1'b0;   // Order still high here is taken again
          state    <= st_idle;
        end

        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      mar <= 16'h0000;
    else if (write_mar)
      mar <= mar_in;
  end

  assign mar_out = mar;
  assign mdr_out = mdr;

  // ========================================
  // Bus protocol checks
  // ========================================
  a_lanes_on_access: assert property (@(posedge clk) disable iff (reset)
    m_access |-> m_bytesel != bytesel_none);

  a_addr_held: assert property (@(posedge clk) disable iff (reset)
    (m_access && !m_ack) |=> $stable(m_addr));

endmodule

/* verilog/lsu_top.sv */
// Memory interface top
// Segment register file feeding the load/store unit.
// Only wiring lives here.

`timescale 1ns/100ps

module lsu_top (
  input  logic              clk,
  input  logic              reset,

  // Segment control
  input  logic              seg_write,
  input  logic [1:0]        seg_wsel,
  input  logic [15:0]       seg_in,
  input  logic [1:0]        seg_rsel,   // Segment for the access

  // MAR / MDR and transfer control
  input  logic              write_mar,
  input  logic [15:0]       mar_in,
  input  logic              write_mdr,
  input  lsu_pkg::bus_word_u mdr_in,
  input  logic              mem_read,
  input  logic              mem_write,
  input  logic              io,
  input  logic              is_8bit,
  output logic [15:0]       mar_out,
  output lsu_pkg::bus_word_u mdr_out,
  output logic              busy,

  // External bus
  output logic [19:1]       m_addr,
  input  lsu_pkg::bus_word_u m_data_in,
  output lsu_pkg::bus_word_u m_data_out,
  output logic [1:0]        m_bytesel,
  output logic              m_wr_en,
  output logic              m_io,
  output logic              m_access,
  input  logic              m_ack
);

  logic [15:0] segment;

  seg_reg_file seg0 (
    .clk       (clk),
    .reset     (reset),
    .seg_write (seg_write),
    .seg_wsel  (seg_wsel),
    .seg_in    (seg_in),
    .seg_rsel  (seg_rsel),
    .segment   (segment)
  );

  load_store ls0 (
    .clk        (clk),
    .reset      (reset),
    .write_mar  (write_mar),
    .mar_in     (mar_in),
    .write_mdr  (write_mdr),
    .mdr_in     (mdr_in),
    .segment    (segment),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .io         (io),
    .is_8bit    (is_8bit),
    .mar_out    (mar_out),
    .mdr_out    (mdr_out),
    .busy       (busy),
    .m_addr     (m_addr),
    .m_data_in  (m_data_in),
    .m_data_out (m_data_out),
    .m_bytesel  (m_bytesel),
    .m_wr_en    (m_wr_en),
    .m_io       (m_io),
    .m_access   (m_access),
    .m_ack      (m_ack)
  );

endmodule

/* tb/lsu_checker.sv */
// Bus and result checker for the load/store unit
// Works out the expected bus cycles of each access from the
// segment, MAR and transfer kind, then compares every bus cycle
// and the read result against them

`timescale 1ns/100ps

module lsu_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        busy,
  input  logic        m_access,
  input  logic        m_ack,
  input  logic [19:1] m_addr,
  input  logic [1:0]  m_bytesel,
  input  logic        m_wr_en,
  input  logic        m_io,
  input  logic [15:0] m_data_out,
  input  logic [15:0] mdr_out,
  input  logic [15:0] mar_out,
  // Current access as set up by the testbench
  input  logic [15:0] c_seg,
  input  logic [15:0] c_mar,
  input  logic [15:0] c_mdr,
  input  logic        c_wr,
  input  logic        c_io,
  input  logic        c_8bit,
  input  logic [15:0] c_exp_mdr,
  output int          errors
);
  import lsu_pkg::*;

  logic        prev_access, prev_busy;
  logic        in_reset;
  int          n_cycles, n_acks;
  logic [19:0] phys;
  logic [19:1] base;
  logic [19:1] exp_addr;
  logic        split;
  logic [1:0]  exp_lanes;
  logic [15:0] exp_data;

  assign phys     = {c_seg, 4'h0} + {4'h0, c_mar};
  assign base     = c_io ? {4'h0, c_mar[15:1]} : phys[19:1];
  assign split    = !c_io && !c_8bit && c_mar[0];
  assign exp_addr = base + 19'(n_cycles);

  task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  // Lanes and write data of bus cycle n, from the lane rules
  always_comb begin
    if (n_cycles == 1) begin
      exp_lanes = bytesel_lo;               // Second half of an odd word
      exp_data  = {8'h00, c_mdr[15:8]};
    end else if (c_8bit) begin
      exp_lanes = c_mar[0] ? bytesel_hi : bytesel_lo;
      exp_data  = c_mar[0] ? {c_mdr[7:0], 8'h00} : {8'h00, c_mdr[7:0]};
    end else if (split) begin
      exp_lanes = bytesel_hi;
      exp_data  = {c_mdr[7:0], 8'h00};
    end else begin
      exp_lanes = bytesel_word;
      exp_data  = c_mdr;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      in_reset    <= 1'b1;
      prev_access <= 1'b0;
      prev_busy   <= 1'b0;
      n_cycles    <= 0;
      n_acks      <= 0;
    end else begin
      in_reset    <= 1'b0;
      prev_access <= m_access;
      prev_busy   <= busy;
      // Reset state of the outputs, first cycle out of reset
      if (in_reset) begin
        if (busy !== 1'b0) report("busy after reset", 32'(busy), 0);
        if (m_access !== 1'b0) report("m_access after reset", 32'(m_access), 0);
        if (m_wr_en !== 1'b0) report("m_wr_en after reset", 32'(m_wr_en), 0);
        if (m_bytesel !== bytesel_none)
          report("m_bytesel after reset", 32'(m_bytesel), 32'(bytesel_none));
        if (m_addr !== '0) report("m_addr after reset", 32'(m_addr), 0);
        if (mar_out !== '0) report("mar_out after reset", 32'(mar_out), 0);
      end
      if (busy && !prev_busy) begin
        n_cycles <= 0;
        n_acks   <= 0;
      end
      // New bus cycle
      if (m_access && !prev_access) begin
        if (m_addr !== exp_addr) report("m_addr", 32'(m_addr), 32'(exp_addr));
        if (m_bytesel !== exp_lanes) report("m_bytesel", 32'(m_bytesel), 32'(exp_lanes));
        if (m_io !== c_io) report("m_io", 32'(m_io), 32'(c_io));
        if (m_wr_en !== c_wr) report("m_wr_en", 32'(m_wr_en), 32'(c_wr));
        if (mar_out !== c_mar) report("mar_out", 32'(mar_out), 32'(c_mar));
        if (c_wr && m_data_out !== exp_data)
          report("m_data_out", 32'(m_data_out), 32'(exp_data));
        n_cycles <= n_cycles + 1;
      end
      if (m_access && m_ack) n_acks <= n_acks + 1;
      // End of transfer
      if (prev_busy && !busy) begin
        if (n_acks != (split ? 2 : 1)) report("bus cycles", n_acks, split ? 2 : 1);
        if (!c_wr && mdr_out !== c_exp_mdr) report("mdr_out", 32'(mdr_out), 32'(c_exp_mdr));
      end
    end
  end

endmodule

/* tb/tb_lsu.sv */
// Testbench for the memory interface top
// Models word memory and I/O ports with random ack delay,
// applies a table of transfers and checks memory contents

`timescale 1ns/100ps

module tb_lsu;
  import lsu_pkg::*;

  typedef struct {
    logic [1:0]  sidx;
    logic [15:0] sval, mar, mdr;
    logic        wr, io, b8;
    logic [15:0] exp;   // Read result, or bytes written
  } row_t;

  localparam int n_rows = 16;
  localparam int cycle_limit = n_rows * 40;

  logic clk, reset;
  logic seg_write, write_mar, write_mdr, mem_read, mem_write, io, is_8bit, busy;
  logic [1:0] seg_wsel, seg_rsel, m_bytesel;
  logic [15:0] seg_in, mar_in, mar_out;
  bus_word_u mdr_in, mdr_out, m_data_in, m_data_out;
  logic [19:1] m_addr;
  logic m_wr_en, m_io, m_access, m_ack;
  logic [15:0] c_seg, c_mar, c_mdr, c_exp;
  logic c_wr, c_io, c_8bit;
  int chk_errors, mem_errors, cycles;
  integer seed;
  logic [15:0] mem [0:65535];
  logic [15:0] io_mem [0:255];
  row_t rows [n_rows];

  lsu_top dut0 (.*);

  lsu_checker chk0 (
    .clk(clk), .reset(reset), .busy(busy), .m_access(m_access), .m_ack(m_ack),
    .m_addr(m_addr), .m_bytesel(m_bytesel), .m_wr_en(m_wr_en), .m_io(m_io),
    .m_data_out(m_data_out), .mdr_out(mdr_out), .mar_out(mar_out), .c_seg(c_seg),
    .c_mar(c_mar), .c_mdr(c_mdr), .c_wr(c_wr), .c_io(c_io), .c_8bit(c_8bit),
    .c_exp_mdr(c_exp), .errors(chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [7:0] mem_byte(input logic [19:0] a);
    return a[0] ? mem[a[16:1]][15:8] : mem[a[16:1]][7:0];
  endfunction

  // ========================================
  // Bus memory and I/O model
  // ========================================
  initial begin
    int delay;
    m_ack = 1'b0;
    m_data_in = '0;
    forever begin
      @(posedge clk); #1;
      if (m_access) begin
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay - 1) begin
          @(posedge clk); #1;
        end
        if (m_io) begin
          m_data_in = io_mem[m_addr[8:1]];
          if (m_wr_en && m_bytesel[0]) io_mem[m_addr[8:1]][7:0] = m_data_out.bytes.lo;
          if (m_wr_en && m_bytesel[1]) io_mem[m_addr[8:1]][15:8] = m_data_out.bytes.hi;
        end else begin
          m_data_in = mem[m_addr[16:1]];
          if (m_wr_en && m_bytesel[0]) mem[m_addr[16:1]][7:0] = m_data_out.bytes.lo;
          if (m_wr_en && m_bytesel[1]) mem[m_addr[16:1]][15:8] = m_data_out.bytes.hi;
        end
        m_ack = 1'b1;
        @(posedge clk); #1;
        m_ack = 1'b0;
      end
    end
  end

  always @(posedge clk) begin   // Run limit
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic apply_row(input row_t r);
    logic [19:0] phys;
    logic [7:0] below, above;
    phys = {r.sval, 4'h0} + {4'h0, r.mar};
    @(posedge clk); #1;
    seg_write = 1'b1;
    seg_wsel  = r.sidx;
    seg_in    = r.sval;
    seg_rsel  = r.sidx;
    write_mar = 1'b1;
    mar_in    = r.mar;
    write_mdr = 1'b1;
    mdr_in    = r.mdr;
    c_seg  = r.sval;
    c_mar  = r.mar;
    c_mdr  = r.mdr;
    c_wr   = r.wr;
    c_io   = r.io;
    c_8bit = r.b8;
    c_exp  = r.exp;
    below = mem_byte(phys - 20'd1);
    above = mem_byte(phys + (r.b8 ? 20'd1 : 20'd2));
    @(posedge clk); #1;
    seg_write = 1'b0;
    write_mar = 1'b0;
    write_mdr = 1'b0;
    io        = r.io;
    is_8bit   = r.b8;
    mem_read  = !r.wr;
    mem_write = r.wr;
    do begin
      @(posedge clk); #1;
    end while (busy);
    mem_read = 1'b0;
    mem_write = 1'b0;
    if (r.wr && !r.io) begin   // Bytes at the physical address and neighbours
      if (mem_byte(phys) !== r.exp[7:0] ||
          (!r.b8 && mem_byte(phys + 20'd1) !== r.exp[15:8]) ||
          mem_byte(phys - 20'd1) !== below ||
          mem_byte(phys + (r.b8 ? 20'd1 : 20'd2)) !== above) begin
        $display("MISMATCH at %0t: memory bytes around %h after write", $time, phys);
        mem_errors++;
      end
    end
    repeat (3) @(posedge clk);
  endtask

  initial begin
    seed = 32'h75eb_97fe;
    cycles = 0;
    mem_errors = 0;
    reset = 1'b1;
    seg_write = 0;
    seg_wsel = 0;
    seg_in = 0;
    seg_rsel = 0;
    write_mar = 0;
    mar_in = 0;
    write_mdr = 0;
    mdr_in = '0;
    mem_read = 0;
    mem_write = 0;
    io = 0;
    is_8bit = 0;
    c_seg = 0;
    c_mar = 0;
    c_mdr = 0;
    c_exp = 0;
    c_wr = 0;
    c_io = 0;
    c_8bit = 0;
    for (int i = 0; i < 65536; i++) mem[i] = 16'($random(seed));
    for (int i = 0; i < 256; i++) io_mem[i] = 16'($random(seed));
    //          seg     value     mar       mdr       wr  io  b8  expected
    rows[0]  = '{seg_ds, 16'h1000, 16'h0100, 16'h1234, 1, 0, 0, 16'h1234};
    rows[1]  = '{seg_ds, 16'h1000, 16'h0100, 16'h0000, 0, 0, 0, 16'h1234};
    rows[2]  = '{seg_es, 16'h0200, 16'h0011, 16'h00a5, 1, 0, 1, 16'h00a5};
    rows[3]  = '{seg_es, 16'h0200, 16'h0011, 16'hffff, 0, 0, 1, 16'h00a5};
    rows[4]  = '{seg_es, 16'h0200, 16'h0010, 16'h775a, 1, 0, 1, 16'h005a};
    rows[5]  = '{seg_es, 16'h0200, 16'h0010, 16'hffff, 0, 0, 1, 16'h005a};
    rows[6]  = '{seg_es, 16'h0200, 16'h0010, 16'h0000, 0, 0, 0, 16'ha55a};
    rows[7]  = '{seg_ss, 16'h0300, 16'h0021, 16'hbeef, 1, 0, 0, 16'hbeef};
    rows[8]  = '{seg_ss, 16'h0300, 16'h0021, 16'h0000, 0, 0, 0, 16'hbeef};
    rows[9]  = '{seg_ss, 16'h0300, 16'h0022, 16'h0000, 0, 0, 1, 16'h00be};
    rows[10] = '{seg_cs, 16'h0400, 16'h0fff, 16'hc0de, 1, 0, 0, 16'hc0de};
    rows[11] = '{seg_cs, 16'h0400, 16'h0fff, 16'h0000, 0, 0, 0, 16'hc0de};
    rows[12] = '{seg_ds, 16'h5000, 16'h0040, 16'h7788, 1, 1, 0, 16'h7788};
    rows[13] = '{seg_ds, 16'h5000, 16'h0040, 16'h0000, 0, 1, 0, 16'h7788};
    rows[14] = '{seg_es, 16'h6000, 16'h0043, 16'h99aa, 1, 1, 0, 16'h99aa};
    rows[15] = '{seg_es, 16'h6000, 16'h0043, 16'h0000, 0, 1, 0, 16'h99aa};
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < n_rows; i++) apply_row(rows[i]);
    repeat (2) @(posedge clk);
    $display("Errors: checker %0d, memory %0d", chk_errors, mem_errors);
    if (chk_errors == 0 && mem_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
verilog/lsu_pkg.sv
verilog/seg_reg_file.sv
verilog/load_store.sv
verilog/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_lsu -o sim_lsu
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_lsu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
